// File: rv_decode.sv
/* RV32I instruction decode */
`timescale 1ns/1ps

module rv_decode (
	input  rv_isa_pkg::word_t     insn,
	input  rv_isa_pkg::word_t     pc,
	input  rv_isa_pkg::word_t     rs1_rdata,
	input  rv_isa_pkg::word_t     rs2_rdata,
	output rv_pipe_pkg::dec_pkt_t pkt
);

	rv_isa_pkg::opcode_t   opcode;
	rv_isa_pkg::funct3_t   funct3;
	rv_isa_pkg::funct7_t   funct7;
	rv_isa_pkg::reg_addr_t rs1_addr;
	rv_isa_pkg::reg_addr_t rs2_addr;
	rv_isa_pkg::word_t     rs1_val;
	rv_isa_pkg::word_t     rs2_val;
	rv_isa_pkg::word_t     imm_i;
	rv_isa_pkg::word_t     imm_s;
	rv_isa_pkg::word_t     imm_b;
	rv_isa_pkg::word_t     imm_u;
	rv_isa_pkg::word_t     imm_j;
	logic                  is_imm;

	assign opcode   = rv_isa_pkg::opcode_t'(insn[6:0]);
	assign funct3   = insn[14:12];
	assign funct7   = insn[31:25];
	assign rs1_addr = insn[19:15];
	assign rs2_addr = insn[24:20];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	// x0 always reads as zero
	assign rs1_val = (rs1_addr == '0) ? '0 : rs1_rdata;
	assign rs2_val = (rs2_addr == '0) ? '0 : rs2_rdata;
	assign is_imm  = (opcode == rv_isa_pkg::OPC_OP_IMM);

	always_comb begin
		pkt           = '0;
		pkt.pc        = pc;
		pkt.op_a      = rs1_val;
		pkt.op_b      = rs2_val;
		pkt.rd_addr   = insn[11:7];
		pkt.alu_op    = rv_isa_pkg::ALU_ADD;
		pkt.branch_op = rv_isa_pkg::BR_NONE;
		pkt.jump      = rv_pipe_pkg::JMP_NONE;
		pkt.mem_size  = rv_isa_pkg::MEM_WORD;
		pkt.illegal   = 1'b1; // Cleared by each legal pattern

		case (opcode)
			rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
				pkt.op_a    = (opcode == rv_isa_pkg::OPC_AUIPC) ? pc : '0;
				pkt.op_b    = imm_u;
				pkt.imm     = imm_u;
				pkt.wr      = 1'b1;
				pkt.illegal = 1'b0;
			end
			rv_isa_pkg::OPC_JAL: begin
				pkt.imm     = imm_j;
				pkt.jump    = rv_pipe_pkg::JMP_JAL;
				pkt.wr      = 1'b1;
				pkt.illegal = 1'b0;
			end
			rv_isa_pkg::OPC_JALR: begin
				pkt.imm     = imm_i;
				pkt.jump    = rv_pipe_pkg::JMP_JALR;
				pkt.wr      = 1'b1;
				pkt.illegal = (funct3 != rv_isa_pkg::F3_JALR);
			end
			rv_isa_pkg::OPC_BRANCH: begin
				pkt.imm     = imm_b;
				pkt.illegal = 1'b0;
				case (funct3)
					rv_isa_pkg::F3_BEQ:  pkt.branch_op = rv_isa_pkg::BR_EQ;
					rv_isa_pkg::F3_BNE:  pkt.branch_op = rv_isa_pkg::BR_NE;
					rv_isa_pkg::F3_BLT:  pkt.branch_op = rv_isa_pkg::BR_LT;
					rv_isa_pkg::F3_BGE:  pkt.branch_op = rv_isa_pkg::BR_GE;
					rv_isa_pkg::F3_BLTU: pkt.branch_op = rv_isa_pkg::BR_LTU;
					rv_isa_pkg::F3_BGEU: pkt.branch_op = rv_isa_pkg::BR_GEU;
					default:             pkt.illegal   = 1'b1; // 010 and 011 reserved
				endcase
			end
			rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE: begin
				pkt.load        = (opcode == rv_isa_pkg::OPC_LOAD);
				pkt.store       = (opcode == rv_isa_pkg::OPC_STORE);
				pkt.wr          = pkt.load;
				pkt.imm         = pkt.load ? imm_i : imm_s;
				pkt.is_unsigned = funct3[2];
				pkt.illegal     = 1'b0;
				case (funct3)
					rv_isa_pkg::F3_LB:  pkt.mem_size = rv_isa_pkg::MEM_BYTE;
					rv_isa_pkg::F3_LH:  pkt.mem_size = rv_isa_pkg::MEM_HALF;
					rv_isa_pkg::F3_LW:  pkt.mem_size = rv_isa_pkg::MEM_WORD;
					rv_isa_pkg::F3_LBU: pkt.mem_size = rv_isa_pkg::MEM_BYTE;
					rv_isa_pkg::F3_LHU: pkt.mem_size = rv_isa_pkg::MEM_HALF;
					default:            pkt.illegal  = 1'b1;
				endcase
				if (pkt.store && funct3[2]) begin
					pkt.illegal = 1'b1; // No unsigned stores
				end
			end
			rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
				pkt.imm = imm_i;
				pkt.wr  = 1'b1;
				if (is_imm) begin
					pkt.op_b = imm_i;
				end
				case (funct3)
					rv_isa_pkg::F3_ADD: begin
						if (is_imm || funct7 == rv_isa_pkg::F7_BASE) begin
							pkt.illegal = 1'b0;
						end else if (funct7 == rv_isa_pkg::F7_ALT) begin
							pkt.alu_op  = rv_isa_pkg::ALU_SUB;
							pkt.illegal = 1'b0;
						end
					end
					rv_isa_pkg::F3_SLL: begin
						pkt.alu_op  = rv_isa_pkg::ALU_SLL;
						pkt.illegal = (funct7 != rv_isa_pkg::F7_BASE);
					end
					rv_isa_pkg::F3_SR: begin
						pkt.alu_op  = (funct7 == rv_isa_pkg::F7_ALT) ?
							rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
						pkt.illegal = (funct7 != rv_isa_pkg::F7_BASE) &&
							(funct7 != rv_isa_pkg::F7_ALT);
					end
					default: begin
						pkt.illegal = !is_imm && (funct7 != rv_isa_pkg::F7_BASE);
						case (funct3)
							rv_isa_pkg::F3_SLT:  pkt.alu_op = rv_isa_pkg::ALU_SLT;
							rv_isa_pkg::F3_SLTU: pkt.alu_op = rv_isa_pkg::ALU_SLTU;
							rv_isa_pkg::F3_XOR:  pkt.alu_op = rv_isa_pkg::ALU_XOR;
							rv_isa_pkg::F3_OR:   pkt.alu_op = rv_isa_pkg::ALU_OR;
							rv_isa_pkg::F3_AND:  pkt.alu_op = rv_isa_pkg::ALU_AND;
							default:             pkt.alu_op = rv_isa_pkg::ALU_ADD;
						endcase
					end
				endcase
			end
			default: begin
				pkt.illegal = 1'b1; // Opcode outside the kept set
			end
		endcase
	end

endmodule

// File: rv_exec_golden.txt
# insn pc rs1 rs2 mem_rdata | mem_addr wstrb rmask wdata | pc_next rd rd_wdata rd_wr trap
# All fields hex; rd and rd_wdata are only compared when rd_wr is 1
002081b3 00000100 11111111 22222222 00000000 00000000 0 0 00000000 00000104 03 33333333 1 0
402081b3 00000104 00000005 00000007 00000000 00000000 0 0 00000000 00000108 03 fffffffe 1 0
002091b3 00000108 00000003 00000024 00000000 00000000 0 0 00000000 0000010c 03 00000030 1 0
0020a1b3 0000010c ffffffff 00000001 00000000 00000000 0 0 00000000 00000110 03 00000001 1 0
0020c1b3 00000114 f0f0f0f0 ff00ff00 00000000 00000000 0 0 00000000 00000118 03 0ff00ff0 1 0
0020d1b3 00000118 80000000 00000004 00000000 00000000 0 0 00000000 0000011c 03 08000000 1 0
4020d1b3 0000011c 80000000 00000004 00000000 00000000 0 0 00000000 00000120 03 f8000000 1 0
0020f1b3 00000124 ffff0000 0f0f0f0f 00000000 00000000 0 0 00000000 00000128 03 0f0f0000 1 0
fff00193 00000128 12345678 00000000 00000000 00000000 0 0 00000000 0000012c 03 ffffffff 1 0
00208033 0000012c 00000001 00000002 00000000 00000000 0 0 00000000 00000130 00 00000000 0 0
4080d193 00000130 87654321 00000000 00000000 00000000 0 0 00000000 00000134 03 ff876543 1 0
123451b7 00000134 00000000 00000000 00000000 00000000 0 0 00000000 00000138 03 12345000 1 0
00001197 00000138 00000000 00000000 00000000 00000000 0 0 00000000 0000013c 03 00001138 1 0
00208863 00000200 00000055 00000055 00000000 00000000 0 0 00000000 00000210 00 00000000 0 0
00209863 00000210 00000055 00000055 00000000 00000000 0 0 00000000 00000214 00 00000000 0 0
fe20cce3 00000300 fffffffe 00000001 00000000 00000000 0 0 00000000 000002f8 00 00000000 0 0
fe20fce3 000002f8 00000001 fffffffe 00000000 00000000 0 0 00000000 000002fc 00 00000000 0 0
020000ef 00000400 00000000 00000000 00000000 00000000 0 0 00000000 00000420 01 00000404 1 0
004081e7 00000420 00001001 00000000 00000000 00000000 0 0 00000000 00001004 03 00000424 1 0
00108183 00000500 00001000 00000000 000000f0 00001001 0 1 00000000 00000504 03 fffffff0 1 0
00209183 00000504 00001000 00000000 12348001 00001002 0 3 00000000 00000508 03 ffff8001 1 0
0040a183 00000508 00001000 00000000 deadbeef 00001004 0 f 00000000 0000050c 03 deadbeef 1 0
0000c183 0000050c 00001000 00000000 000000f0 00001000 0 1 00000000 00000510 03 000000f0 1 0
0000d183 00000510 00001000 00000000 ffff8001 00001000 0 3 00000000 00000514 03 00008001 1 0
002081a3 00000600 00002000 aabbccdd 00000000 00002003 1 0 aabbccdd 00000604 00 00000000 0 0
00209123 00000604 00002000 11223344 00000000 00002002 3 0 11223344 00000608 00 00000000 0 0
0020a423 00000608 00002000 cafef00d 00000000 00002008 f 0 cafef00d 0000060c 00 00000000 0 0
00000000 00000700 00000000 00000000 00000000 00000000 0 0 00000000 00000700 00 00000000 0 1
0020a863 00000704 00000055 00000055 00000000 00000000 0 0 00000000 00000704 00 00000000 0 1
002000ef 00000708 00000000 00000000 00000000 00000000 0 0 00000000 00000708 00 00000000 0 1
0020a183 0000070c 00001000 00000000 00000000 00000000 0 0 00000000 0000070c 00 00000000 0 1
002090a3 00000710 00002000 11223344 00000000 00000000 0 0 00000000 00000710 00 00000000 0 1

// File: rv_exec_top.sv
/* Pipelined RV32I evaluator */
`timescale 1ns/1ps

module rv_exec_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  rv_isa_pkg::word_t     in_insn,
	input  rv_isa_pkg::word_t     in_pc,
	input  rv_isa_pkg::word_t     in_rs1_rdata,
	input  rv_isa_pkg::word_t     in_rs2_rdata,
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output rv_isa_pkg::word_t     mem_addr,
	output rv_isa_pkg::word_t     mem_wdata,
	output rv_isa_pkg::strb_t     mem_wstrb,
	output rv_isa_pkg::strb_t     mem_rmask,
	input  rv_isa_pkg::word_t     mem_rdata,
	output logic                  out_valid,
	input  logic                  out_ready,
	output rv_isa_pkg::word_t     out_pc_next,
	output rv_isa_pkg::reg_addr_t out_rd_addr,
	output rv_isa_pkg::word_t     out_rd_wdata,
	output logic                  out_rd_wr,
	output logic                  out_trap
);

	rv_pipe_pkg::dec_pkt_t dec_in;
	rv_pipe_pkg::dec_pkt_t dec_q;
	rv_pipe_pkg::exe_pkt_t exe_in;
	rv_pipe_pkg::exe_pkt_t exe_q;
	logic                  dec_valid;
	logic                  exe_ready;
	logic                  exe_valid;
	logic                  mem_in_ready;

	rv_decode u_decode (
		.insn      (in_insn),
		.pc        (in_pc),
		.rs1_rdata (in_rs1_rdata),
		.rs2_rdata (in_rs2_rdata),
		.pkt       (dec_in)
	);

	rv_pipe_reg #(.payload_t(rv_pipe_pkg::dec_pkt_t)) u_dec_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (dec_in),
		.in_ready  (in_ready),
		.out_valid (dec_valid),
		.out_data  (dec_q),
		.out_ready (exe_ready)
	);

	rv_execute u_execute (
		.dec (dec_q),
		.exe (exe_in)
	);

	rv_pipe_reg #(.payload_t(rv_pipe_pkg::exe_pkt_t)) u_exe_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (dec_valid),
		.in_data   (exe_in),
		.in_ready  (exe_ready),
		.out_valid (exe_valid),
		.out_data  (exe_q),
		.out_ready (mem_in_ready)
	);

	rv_mem_access u_mem_access (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (exe_valid),
		.exe          (exe_q),
		.in_ready     (mem_in_ready),
		.mem_valid    (mem_valid),
		.mem_ready    (mem_ready),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_wstrb    (mem_wstrb),
		.mem_rmask    (mem_rmask),
		.mem_rdata    (mem_rdata),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_pc_next  (out_pc_next),
		.out_rd_addr  (out_rd_addr),
		.out_rd_wdata (out_rd_wdata),
		.out_rd_wr    (out_rd_wr),
		.out_trap     (out_trap)
	);

endmodule

// File: rv_execute.sv
/* RV32I execute stage */
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_execute (
	input  rv_pipe_pkg::dec_pkt_t dec,
	output rv_pipe_pkg::exe_pkt_t exe
);

	rv_isa_pkg::word_t a;
	rv_isa_pkg::word_t b;
	rv_isa_pkg::word_t alu_res;
	rv_isa_pkg::word_t addr;
	rv_isa_pkg::word_t target;
	rv_isa_pkg::word_t pc_plus4;
	rv_isa_pkg::word_t pc_next;
	logic              taken;
	logic              is_mem;
	logic              misalign_pc;
	logic              misalign_mem;
	logic              trap;

	assign a        = dec.op_a;
	assign b        = dec.op_b;
	assign addr     = a + dec.imm;  // Load/store address and JALR target
	assign target   = dec.pc + dec.imm;
	assign pc_plus4 = dec.pc + `RV_PC_STEP;
	assign is_mem   = dec.load || dec.store;

	always_comb begin
		case (dec.alu_op)
			rv_isa_pkg::ALU_SUB:  alu_res = a - b;
			rv_isa_pkg::ALU_SLL:  alu_res = a << b[4:0];
			rv_isa_pkg::ALU_SLT:  alu_res = {31'b0, $signed(a) < $signed(b)};
			rv_isa_pkg::ALU_SLTU: alu_res = {31'b0, a < b};
			rv_isa_pkg::ALU_XOR:  alu_res = a ^ b;
			rv_isa_pkg::ALU_SRL:  alu_res = a >> b[4:0];
			rv_isa_pkg::ALU_SRA:  alu_res = $signed(a) >>> b[4:0];
			rv_isa_pkg::ALU_OR:   alu_res = a | b;
			rv_isa_pkg::ALU_AND:  alu_res = a & b;
			default:              alu_res = a + b;
		endcase
	end

	always_comb begin
		case (dec.branch_op)
			rv_isa_pkg::BR_EQ:  taken = (a == b);
			rv_isa_pkg::BR_NE:  taken = (a != b);
			rv_isa_pkg::BR_LT:  taken = $signed(a) < $signed(b);
			rv_isa_pkg::BR_GE:  taken = $signed(a) >= $signed(b);
			rv_isa_pkg::BR_LTU: taken = a < b;
			rv_isa_pkg::BR_GEU: taken = a >= b;
			default:            taken = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.jump)
			rv_pipe_pkg::JMP_JAL:  pc_next = target;
			rv_pipe_pkg::JMP_JALR: pc_next = {addr[31:1], 1'b0};
			default:               pc_next = taken ? target : pc_plus4;
		endcase
	end

	assign misalign_pc  = |pc_next[1:0];
	assign misalign_mem = is_mem &&
		(((dec.mem_size == rv_isa_pkg::MEM_HALF) && addr[0]) ||
		 ((dec.mem_size == rv_isa_pkg::MEM_WORD) && |addr[1:0]));
	assign trap = dec.illegal || misalign_pc || misalign_mem;

	always_comb begin
		exe             = '0;
		exe.pc_next     = trap ? dec.pc : pc_next; // Stall on the faulting insn
		exe.rd_addr     = dec.rd_addr;
		exe.store_data  = b;
		exe.is_unsigned = dec.is_unsigned;
		exe.mem_size    = dec.mem_size;
		exe.load        = dec.load && !trap;
		exe.store       = dec.store && !trap;
		exe.wr          = dec.wr && (dec.rd_addr != '0) && !trap;
		exe.trap        = trap;
		if (is_mem) begin
			exe.result = addr;
		end else if (dec.jump != rv_pipe_pkg::JMP_NONE) begin
			exe.result = pc_plus4; // Link value
		end else begin
			exe.result = alu_res;
		end
	end

endmodule

// File: rv_isa_pkg.sv
/* RV32I instruction set types */
`include "rv_macros.svh"

package rv_isa_pkg;

	typedef logic [`RV_XLEN-1:0]   word_t;
	typedef logic [`RV_REG_AW-1:0] reg_addr_t;
	typedef logic [`RV_STRB_W-1:0] strb_t;
	typedef logic [2:0]            funct3_t;
	typedef logic [6:0]            funct7_t;

	// Major opcodes kept by the evaluator
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_t;

	localparam funct3_t F3_JALR = 3'b000;

	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_LB  = 3'b000; // Also SB
	localparam funct3_t F3_LH  = 3'b001; // Also SH
	localparam funct3_t F3_LW  = 3'b010; // Also SW
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;

	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000; // SUB and SRA

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} branch_op_t;

	typedef enum logic [1:0] {
		MEM_BYTE, MEM_HALF, MEM_WORD
	} mem_size_t;

endpackage

// File: rv_macros.svh
/* RV32 width macros */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data and address width
`define RV_XLEN 32

// Register index width
`define RV_REG_AW 5

// Byte lanes per word
`define RV_STRB_W 4

// Sequential pc increment
`define RV_PC_STEP 4

`endif

// File: rv_mem_access.sv
/* Data memory access and writeback */
`timescale 1ns/1ps

module rv_mem_access (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  rv_pipe_pkg::exe_pkt_t exe,
	output logic                  in_ready,
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output rv_isa_pkg::word_t     mem_addr,
	output rv_isa_pkg::word_t     mem_wdata,
	output rv_isa_pkg::strb_t     mem_wstrb,
	output rv_isa_pkg::strb_t     mem_rmask,
	input  rv_isa_pkg::word_t     mem_rdata,
	output logic                  out_valid,
	input  logic                  out_ready,
	output rv_isa_pkg::word_t     out_pc_next,
	output rv_isa_pkg::reg_addr_t out_rd_addr,
	output rv_isa_pkg::word_t     out_rd_wdata,
	output logic                  out_rd_wr,
	output logic                  out_trap
);

	logic              is_mem;
	logic              out_space;
	logic              take;
	rv_isa_pkg::strb_t lane_mask;
	rv_isa_pkg::word_t load_data;

	assign is_mem    = exe.load || exe.store;
	assign out_space = !out_valid || out_ready;

	// Request only once the result slot is free, so it holds until mem_ready
	assign mem_valid = in_valid && is_mem && out_space;
	assign in_ready  = out_space && (!is_mem || mem_ready);
	assign take      = in_valid && in_ready;

	always_comb begin
		case (exe.mem_size)
			rv_isa_pkg::MEM_BYTE: lane_mask = 4'b0001;
			rv_isa_pkg::MEM_HALF: lane_mask = 4'b0011;
			default:              lane_mask = 4'b1111;
		endcase
	end

	assign mem_addr  = exe.result;
	assign mem_wdata = exe.store ? exe.store_data : '0; // Lane 0 aligned
	assign mem_wstrb = (mem_valid && exe.store) ? lane_mask : '0;
	assign mem_rmask = (mem_valid && exe.load) ? lane_mask : '0;

	always_comb begin
		case (exe.mem_size)
			rv_isa_pkg::MEM_BYTE:
				load_data = {{24{mem_rdata[7] && !exe.is_unsigned}}, mem_rdata[7:0]};
			rv_isa_pkg::MEM_HALF:
				load_data = {{16{mem_rdata[15] && !exe.is_unsigned}}, mem_rdata[15:0]};
			default:
				load_data = mem_rdata;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (out_space) begin
			out_valid <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_pc_next  <= exe.pc_next;
			out_rd_addr  <= exe.rd_addr;
			out_rd_wdata <= exe.load ? load_data : exe.result;
			out_rd_wr    <= exe.wr;
			out_trap     <= exe.trap;
		end
	end

	// Pending request stays put until the memory takes it
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) &&
		$stable(mem_wdata) && $stable(mem_wstrb) && $stable(mem_rmask));

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!((|mem_wstrb) && (|mem_rmask)));

endmodule

// File: rv_pipe_pkg.sv
/* Pipeline stage payloads */
package rv_pipe_pkg;

	typedef enum logic [1:0] {
		JMP_NONE,
		JMP_JAL,
		JMP_JALR
	} jump_kind_t;

	// Decode to execute
	typedef struct packed {
		rv_isa_pkg::word_t      pc;
		rv_isa_pkg::word_t      op_a;        // rs1, pc or zero
		rv_isa_pkg::word_t      op_b;        // rs2 or immediate
		rv_isa_pkg::word_t      imm;
		rv_isa_pkg::reg_addr_t  rd_addr;
		rv_isa_pkg::alu_op_t    alu_op;
		rv_isa_pkg::branch_op_t branch_op;
		jump_kind_t             jump;
		logic                   load;
		logic                   store;
		logic                   is_unsigned;
		rv_isa_pkg::mem_size_t  mem_size;
		logic                   wr;
		logic                   illegal;
	} dec_pkt_t;

	// Execute to memory access
	typedef struct packed {
		rv_isa_pkg::word_t     pc_next;
		rv_isa_pkg::reg_addr_t rd_addr;
		rv_isa_pkg::word_t     result;      // ALU value or access address
		rv_isa_pkg::word_t     store_data;
		logic                  load;
		logic                  store;
		logic                  is_unsigned;
		rv_isa_pkg::mem_size_t mem_size;
		logic                  wr;
		logic                  trap;
	} exe_pkt_t;

endpackage

// File: rv_pipe_reg.sv
/* Valid/ready stage register */
`timescale 1ns/1ps

module rv_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	// Empty, or the held entry leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

	// Consumer sees a frozen payload while it stalls
	a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: tb.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_pipe_reg.sv
rv_decode.sv
rv_execute.sv
rv_mem_access.sv
rv_exec_top.sv
tb_rv_exec.sv

// File: tb_rv_exec.sv
/* Pipelined RV32I evaluator testbench */
`timescale 1ns/1ps

module tb_rv_exec;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	logic                  in_ready;
	rv_isa_pkg::word_t     in_insn;
	rv_isa_pkg::word_t     in_pc;
	rv_isa_pkg::word_t     in_rs1_rdata;
	rv_isa_pkg::word_t     in_rs2_rdata;
	logic                  mem_valid;
	logic                  mem_ready;
	rv_isa_pkg::word_t     mem_addr;
	rv_isa_pkg::word_t     mem_wdata;
	rv_isa_pkg::strb_t     mem_wstrb;
	rv_isa_pkg::strb_t     mem_rmask;
	rv_isa_pkg::word_t     mem_rdata;
	logic                  out_valid;
	logic                  out_ready;
	rv_isa_pkg::word_t     out_pc_next;
	rv_isa_pkg::reg_addr_t out_rd_addr;
	rv_isa_pkg::word_t     out_rd_wdata;
	logic                  out_rd_wr;
	logic                  out_trap;

	// One entry per golden line
	rv_isa_pkg::word_t     g_insn[$];
	rv_isa_pkg::word_t     g_pc[$];
	rv_isa_pkg::word_t     g_rs1[$];
	rv_isa_pkg::word_t     g_rs2[$];
	rv_isa_pkg::word_t     g_rdata[$];
	rv_isa_pkg::word_t     g_addr[$];
	rv_isa_pkg::strb_t     g_wstrb[$];
	rv_isa_pkg::strb_t     g_rmask[$];
	rv_isa_pkg::word_t     g_wdata[$];
	rv_isa_pkg::word_t     g_pc_next[$];
	rv_isa_pkg::reg_addr_t g_rd[$];
	rv_isa_pkg::word_t     g_rd_wdata[$];
	logic                  g_rd_wr[$];
	logic                  g_trap[$];
	int                    mem_list[$]; // Vector indices that touch memory

	int nvec    = 0;
	int out_ptr = 0; // Next expected result
	int mem_pos = 0; // Next expected memory access
	int cycles  = 0;
	int limit   = 0;
	bit loaded  = 1'b0;

	rv_exec_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_insn      (in_insn),
		.in_pc        (in_pc),
		.in_rs1_rdata (in_rs1_rdata),
		.in_rs2_rdata (in_rs2_rdata),
		.mem_valid    (mem_valid),
		.mem_ready    (mem_ready),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_wstrb    (mem_wstrb),
		.mem_rmask    (mem_rmask),
		.mem_rdata    (mem_rdata),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_pc_next  (out_pc_next),
		.out_rd_addr  (out_rd_addr),
		.out_rd_wdata (out_rd_wdata),
		.out_rd_wr    (out_rd_wr),
		.out_trap     (out_trap)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input int idx,
			input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp);
		if (got !== exp) begin
			fail_now($sformatf("[ERROR] %s (vector %0d) got 0x%08h expected 0x%08h",
				name, idx, got, exp));
		end
	endtask

	task automatic check_reg(input string name, input int idx,
			input rv_isa_pkg::reg_addr_t got, input rv_isa_pkg::reg_addr_t exp);
		if (got !== exp) begin
			fail_now($sformatf("[ERROR] %s (vector %0d) got 0x%02h expected 0x%02h",
				name, idx, got, exp));
		end
	endtask

	task automatic check_strb(input string name, input int idx,
			input rv_isa_pkg::strb_t got, input rv_isa_pkg::strb_t exp);
		if (got !== exp) begin
			fail_now($sformatf("[ERROR] %s (vector %0d) got 0x%1h expected 0x%1h",
				name, idx, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input int idx, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("[ERROR] %s (vector %0d) got 0x%1h expected 0x%1h",
				name, idx, got, exp));
		end
	endtask

	task automatic load_golden();
		int                    fd;
		int                    n;
		string                 line;
		rv_isa_pkg::word_t     insn, pc, rs1, rs2, rdata, addr, wdata, pcn, rdw;
		rv_isa_pkg::strb_t     wstrb, rmask;
		rv_isa_pkg::reg_addr_t rd;
		logic                  wr, trap;
		fd = $fopen("rv_exec_golden.txt", "r");
		if (fd == 0) begin
			fail_now("Could not open the golden vector file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin // Skip comments and blanks
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					insn, pc, rs1, rs2, rdata, addr, wstrb, rmask, wdata,
					pcn, rd, rdw, wr, trap);
				if (n != 14) begin
					fail_now($sformatf("Golden line has %0d fields instead of 14", n));
				end
				g_insn.push_back(insn);
				g_pc.push_back(pc);
				g_rs1.push_back(rs1);
				g_rs2.push_back(rs2);
				g_rdata.push_back(rdata);
				g_addr.push_back(addr);
				g_wstrb.push_back(wstrb);
				g_rmask.push_back(rmask);
				g_wdata.push_back(wdata);
				g_pc_next.push_back(pcn);
				g_rd.push_back(rd);
				g_rd_wdata.push_back(rdw);
				g_rd_wr.push_back(wr);
				g_trap.push_back(trap);
				if (wstrb != '0 || rmask != '0) begin
					mem_list.push_back(g_insn.size() - 1);
				end
			end
		end
		$fclose(fd);
	endtask

	// Compare a pending request with the next memory vector
	task automatic check_request();
		int v;
		if (mem_pos >= mem_list.size()) begin
			fail_now("DUT issued a memory request that no vector expects");
		end else begin
			v = mem_list[mem_pos];
			check_word("mem_addr", v, mem_addr, g_addr[v]);
			check_strb("mem_wstrb", v, mem_wstrb, g_wstrb[v]);
			check_strb("mem_rmask", v, mem_rmask, g_rmask[v]);
			check_word("mem_wdata", v, mem_wdata, g_wdata[v]);
		end
	endtask

	// Stimulus and end of run
	initial begin
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_insn      = '0;
		in_pc        = '0;
		in_rs1_rdata = '0;
		in_rs2_rdata = '0;
		void'($urandom(32'hebc58654));
		load_golden();
		nvec   = g_insn.size();
		limit  = nvec * 20 + 100;
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int i = 0; i < nvec; i++) begin
			if ($urandom_range(0, 3) == 0) begin // Occasional input bubble
				in_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			in_valid     = 1'b1;
			in_insn      = g_insn[i];
			in_pc        = g_pc[i];
			in_rs1_rdata = g_rs1[i];
			in_rs2_rdata = g_rs2[i];
			@(posedge clk);
			while (!in_ready) begin
				@(posedge clk);
			end
			#1;
		end
		in_valid = 1'b0;
		while (out_ptr < nvec) begin
			@(posedge clk);
		end
		repeat (5) @(posedge clk); // Catch late extra results
		if (mem_pos == mem_list.size()) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Memory access count differs from the golden vectors");
			$display("Regression failed");
			$fatal(1, "memory access count mismatch");
		end
	end

	// out_ready low in about 30% of cycles
	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1 out_ready = ($urandom_range(0, 9) >= 3);
		end
	end

	// Memory responder with 0 to 3 extra wait cycles
	initial begin
		int wait_left;
		mem_ready = 1'b0;
		mem_rdata = '0;
		wait_left = -1;
		forever begin
			@(posedge clk);
			if (rst_n && mem_valid && mem_ready) begin
				mem_pos++;
				wait_left = -1;
				#1;
				mem_ready = 1'b0;
				mem_rdata = '0;
			end else if (rst_n && mem_valid) begin
				if (wait_left < 0) begin
					check_request();
					wait_left = $urandom_range(0, 3);
				end
				if (wait_left == 0) begin
					#1;
					mem_ready = 1'b1;
					mem_rdata = g_rdata[mem_list[mem_pos]];
				end else begin
					wait_left--;
				end
			end
		end
	end

	// Results checked strictly in vector order
	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			if (out_ptr >= nvec) begin
				fail_now("DUT produced a result that no vector expects");
			end else begin
				check_word("out_pc_next", out_ptr, out_pc_next, g_pc_next[out_ptr]);
				check_bit("out_trap", out_ptr, out_trap, g_trap[out_ptr]);
				check_bit("out_rd_wr", out_ptr, out_rd_wr, g_rd_wr[out_ptr]);
				if (g_rd_wr[out_ptr]) begin
					check_reg("out_rd_addr", out_ptr, out_rd_addr, g_rd[out_ptr]);
					check_word("out_rd_wdata", out_ptr, out_rd_wdata, g_rd_wdata[out_ptr]);
				end
				out_ptr++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (loaded && cycles > limit) begin
			fail_now($sformatf("Timeout: results did not complete within %0d cycles", limit));
		end
	end

endmodule
